// ==== list.f ====
+incdir+verilog
+incdir+tests
verilog/cart_pkg.sv
verilog/cart_header_scan.sv
verilog/cart_quirk_table.sv
verilog/region_select.sv
verilog/rom_write_bridge.sv
verilog/cart_loader_top.sv
tests/cart_loader_tb.sv

// ==== tests/cart_ref.svh ====
// Testbench reference models, LFSR and cartridge image builder, included inside the testbench
`ifndef CART_REF_SVH
`define CART_REF_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Byte image with header fields placed over a fill pattern
task automatic build_image(input logic [7:0] lo0, input logic [7:0] hi0, input logic [7:0] lo1,
	input logic [63:0] code, input logic [7:0] salt);
	for (int i = 0; i < IMG_BYTES; i++)
		img_b[i] = i[7:0] ^ {4{i[9:8]}} ^ salt;
	for (int i = 0; i < 8; i++)
		img_b['h183 + i] = code[63 - 8*i -: 8];   // First character at 'h183
	img_b['h1F0] = lo0;
	img_b['h1F1] = hi0;
	img_b['h1F2] = lo1;
endtask

function automatic region_flags_t region_letter(input logic [7:0] ch);
	case (ch)
		"J": return 3'b001;
		"U": return 3'b010;
		"E": return 3'b100;
		default: return 3'b000;
	endcase
endfunction

// Flags after the three region bytes of a fresh download
function automatic region_flags_t ref_region_flags(input logic [7:0] lo0, input logic [7:0] hi0,
	input logic [7:0] lo1);
	region_flags_t f;
	logic [3:0]    n;
	f = '0;
	if (region_letter(lo0) != 3'b000)
		f = region_letter(lo0);
	else if (lo0 >= "0" && lo0 <= "9")
		f = {lo0[3], lo0[2], lo0[0]};
	else if (lo0 >= "A" && lo0 <= "F") begin
		n = lo0[3:0] - 4'd7;
		f = {n[3], n[2], n[0]};
	end
	return f | region_letter(hi0) | region_letter(lo1);
endfunction

// Region value doubles as its flag bit index
function automatic region_t ref_region(input region_order_t order, input region_flags_t flags);
	logic [5:0] seq;
	region_t    r;
	case (order)
		ORDER_US_EU_JP: seq = {REGION_US, REGION_EU, REGION_JP};
		ORDER_EU_US_JP: seq = {REGION_EU, REGION_US, REGION_JP};
		ORDER_US_JP_EU: seq = {REGION_US, REGION_JP, REGION_EU};
		default:        seq = {REGION_JP, REGION_US, REGION_EU};
	endcase
	r = region_t'(seq[5:4]);                       // Fallback is the first of the order
	for (int i = 0; i < 3; i++)
		if (flags[seq[2*i +: 2]])
			r = region_t'(seq[2*i +: 2]);
	return r;
endfunction

// {sram, eeprom, fifo, svp, gun_type, gun_delay}
function automatic logic [12:0] ref_quirks(input logic [63:0] code);
	logic [3:0] q;
	logic [8:0] gun;
	case (code)
		"T-081276", "T-81406 ", "T-081586": q = 4'b1000;
		"MK-1215 ", "G-4060  ", "T-12046 ": q = 4'b0100;
		"T-89016 ": q = 4'b0010;
		"MK-1229 ", "G-7001  ": q = 4'b0001;
		default: q = 4'b0000;
	endcase
	case (code)
		"MK-1533 ": gun = {1'b0, 8'd100};
		"T-95096-": gun = {1'b1, 8'd52};
		"T-95136-": gun = {1'b1, 8'd30};
		"MK-1658 ": gun = {1'b0, 8'd120};
		"T-081156": gun = {1'b0, 8'd126};
		default:    gun = {1'b0, 8'd44};
	endcase
	return {q, gun};
endfunction

function automatic logic [15:0] ref_rom_word(input logic [15:0] w);
	return {w[7:0], w[15:8]};
endfunction

`endif

// ==== tests/cart_loader_tb.sv ====
// Testbench for the cartridge loader that drives download images and models the ROM memory
`timescale 1ns/1ps
`default_nettype none

module cart_loader_tb;
	import cart_pkg::*;

	localparam int IMG_BYTES   = 1024;
	localparam int IMG_WORDS   = IMG_BYTES / 2;
	localparam int NUM_CASES   = 13;
	localparam int CYCLE_LIMIT = 40 * NUM_CASES * IMG_WORDS + 1000;

	logic          clk_sys, RESET, cart_download, ioctl_wr, ioctl_wait;
	logic [7:0]    download_index;
	cart_addr_t    ioctl_addr, rom_size;
	cart_word_t    ioctl_data, mem_data;
	rom_addr_t     mem_addr, got_a;
	logic          mem_req, mem_ack, auto_disable, use_header, region_set;
	region_order_t region_priority;
	region_flags_t hdr_flags_out;
	region_t       region_req;
	logic          sram_quirk, eeprom_quirk, fifo_quirk, svp_quirk, gun_type;
	gun_delay_t    gun_delay;

	logic [7:0]    img_b [0:IMG_BYTES-1];
	cart_word_t    rom_mem [0:IMG_WORDS-1];  // Memory model contents
	logic [39:0]   exp_q [$];                // {word address, swapped word}
	rom_addr_t     got_q [$];
	logic [39:0]   exp_e;
	logic [31:0]   lfsr_state = 32'h6a3e3490;
	int            cycles = 0;
	int            wr_count = 0;

	`include "cart_ref.svh"

	cart_loader_top UUT (.*);

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		abort_run($sformatf("ERROR at %0d ns: %s", $time, msg));
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT)
			abort_run($sformatf("Timeout, run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	// A pending ROM write must keep the download held
	always @(posedge clk_sys) begin
		if (!RESET) begin
			assert (mem_req == mem_ack || ioctl_wait)
			else report_mismatch("ROM write pending with ioctl_wait low");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// ROM memory with random acknowledge delay

	initial begin
		logic [2:0] delay;
		mem_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (!RESET && (mem_req != mem_ack)) begin
				rom_mem[mem_addr[8:0]] = mem_data;
				got_q.push_back(mem_addr);
				wr_count++;
				delay = '0;
				repeat (3) begin                 // One LFSR step per delay bit
					lfsr_state = lfsr_next(lfsr_state);
					delay = {delay[1:0], lfsr_state[0]};
				end
				repeat (delay) begin
					@(posedge clk_sys);
					#1;
				end
				mem_ack = mem_req;
			end
		end
	end

	// Each stored write against the next word sent
	always @(posedge clk_sys) begin
		if (got_q.size() > 0) begin
			got_a = got_q.pop_front();
			assert (exp_q.size() > 0)
			else report_mismatch($sformatf("extra ROM write at %h", got_a));
			exp_e = exp_q.pop_front();
			assert (got_a == exp_e[39:16] && rom_mem[got_a[8:0]] == exp_e[15:0])
			else report_mismatch($sformatf("ROM write %h=%h, expected %h=%h", got_a,
				rom_mem[got_a[8:0]], exp_e[39:16], exp_e[15:0]));
		end
	end

	//////////////////////////////////////////////////////////////////////
	// One full image download and its results

	task automatic run_case(input logic [7:0] lo0, input logic [7:0] hi0, input logic [7:0] lo1,
		input logic [63:0] code, input region_order_t order, input logic hdr_on,
		input logic [7:0] index);
		region_flags_t flags;
		region_t       want_req;
		logic          want_set;
		cart_word_t    word;
		flags    = ref_region_flags(lo0, hi0, lo1);
		want_req = hdr_on ? ref_region(order, flags) : region_t'(index[7:6]);
		want_set = hdr_on | (|index);
		build_image(lo0, hi0, lo1, code, code[7:0] ^ code[23:16]);
		wr_count        = 0;
		use_header      = hdr_on;
		region_priority = order;
		download_index  = index;
		cart_download   = 1'b1;
		@(posedge clk_sys);
		#1;
		assert (hdr_flags_out == 3'b000
			&& {sram_quirk, eeprom_quirk, fifo_quirk, svp_quirk} == 4'b0)
		else report_mismatch("flags or quirks not cleared at download start");
		for (int w = 0; w < IMG_WORDS; w++) begin
			word       = {img_b[2*w+1], img_b[2*w]};
			ioctl_addr = cart_addr_t'(2 * w);
			ioctl_data = word;
			ioctl_wr   = 1'b1;
			exp_q.push_back({rom_addr_t'(w), ref_rom_word(word)});
			@(posedge clk_sys);
			#1;
			ioctl_wr = 1'b0;
			assert (ioctl_wait) else report_mismatch("ioctl_wait not raised after a write");
			while (ioctl_wait) begin             // Source holds its next word
				@(posedge clk_sys);
				#1;
			end
		end
		repeat (2) @(posedge clk_sys);
		#1;
		assert (exp_q.size() == 0 && wr_count == IMG_WORDS)
		else report_mismatch($sformatf("%0d ROM writes for %0d words", wr_count, IMG_WORDS));
		assert (hdr_flags_out == flags)
		else report_mismatch($sformatf("header flags %b, expected %b", hdr_flags_out, flags));
		assert (region_req == want_req && region_set == want_set)
		else report_mismatch($sformatf("region %0d set %b, expected %0d set %b",
			region_req, region_set, want_req, want_set));
		assert ({sram_quirk, eeprom_quirk, fifo_quirk, svp_quirk, gun_type, gun_delay}
			== ref_quirks(code))
		else report_mismatch($sformatf("quirks wrong for code %s", code));
		cart_download = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
		assert (rom_size == cart_addr_t'(IMG_BYTES - 2) && region_set == 1'b0)
		else report_mismatch($sformatf("rom_size %h region_set %b after download", rom_size,
			region_set));
	endtask

	initial begin
		RESET           = 1'b1;
		cart_download   = 1'b0;
		download_index  = '0;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		auto_disable    = 1'b0;
		use_header      = 1'b0;
		region_priority = ORDER_US_EU_JP;
		repeat (5) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		assert (mem_req == 1'b0 && ioctl_wait == 1'b0 && rom_size == '0 && region_set == 1'b0
			&& {sram_quirk, eeprom_quirk, fifo_quirk, svp_quirk, gun_type} == 5'b0
			&& gun_delay == 8'd44)
		else report_mismatch("outputs wrong after reset");

		// Letter, digit and hex region strings with table titles
		run_case("J", "U", "E", "T-081276", ORDER_US_EU_JP, 1'b1, 8'h00);
		run_case("E", " ", " ", "MK-1215 ", ORDER_EU_US_JP, 1'b1, 8'h00);
		run_case("8", " ", " ", "T-89016 ", ORDER_US_JP_EU, 1'b1, 8'h00);
		run_case("4", " ", " ", "MK-1229 ", ORDER_JP_US_EU, 1'b1, 8'h00);
		run_case("1", "E", " ", "MK-1533 ", ORDER_US_EU_JP, 1'b1, 8'h00);
		run_case("F", " ", " ", "T-95096-", ORDER_JP_US_EU, 1'b1, 8'h00);
		run_case("A", " ", " ", "T-95136-", ORDER_US_JP_EU, 1'b1, 8'h00);
		// No flags, so each order falls back
		run_case(" ", " ", " ", "MK-1658 ", ORDER_US_EU_JP, 1'b1, 8'h00);
		run_case(" ", " ", " ", "T-081156", ORDER_EU_US_JP, 1'b1, 8'h00);
		run_case(" ", " ", " ", "XYZ-0000", ORDER_US_JP_EU, 1'b1, 8'h00);
		run_case(" ", " ", " ", "G-4060  ", ORDER_JP_US_EU, 1'b1, 8'h00);
		// Region from the download index
		run_case(" ", "U", " ", "XYZ-0000", ORDER_US_EU_JP, 1'b0, 8'h80);
		run_case("J", " ", " ", "T-12046 ", ORDER_EU_US_JP, 1'b0, 8'h00);

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cart_loader_top.sv ====
// Cartridge loader top: ROM write path, header scan, title quirks and region selection
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top (
	input  logic                    clk_sys,
	input  logic                    RESET,
	// Download source
	input  logic                    cart_download,
	input  logic [7:0]              download_index,
	input  logic                    ioctl_wr,
	input  cart_pkg::cart_addr_t    ioctl_addr,
	input  cart_pkg::cart_word_t    ioctl_data,
	output logic                    ioctl_wait,
	// ROM memory
	output cart_pkg::rom_addr_t     mem_addr,
	output cart_pkg::cart_word_t    mem_data,
	output logic                    mem_req,
	input  logic                    mem_ack,
	output cart_pkg::cart_addr_t    rom_size,
	// Region options and result
	input  logic                    auto_disable,
	input  logic                    use_header,
	input  cart_pkg::region_order_t region_priority,
	output cart_pkg::region_flags_t hdr_flags_out,
	output cart_pkg::region_t       region_req,
	output logic                    region_set,
	// Title quirks
	output logic                    sram_quirk,
	output logic                    eeprom_quirk,
	output logic                    fifo_quirk,
	output logic                    svp_quirk,
	output logic                    gun_type,
	output cart_pkg::gun_delay_t    gun_delay
);
	import cart_pkg::*;

	cart_id_t cart_id;
	logic     id_check;
	logic     hdr_ready;

	rom_write_bridge u_bridge (
		.clk_sys(clk_sys), .RESET(RESET),
		.cart_download(cart_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wait(ioctl_wait),
		.mem_addr(mem_addr), .mem_data(mem_data), .mem_req(mem_req), .mem_ack(mem_ack),
		.rom_size(rom_size)
	);

	cart_header_scan u_scan (
		.clk_sys(clk_sys), .RESET(RESET),
		.cart_download(cart_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.hdr_flags(hdr_flags_out), .cart_id(cart_id), .id_check(id_check),
		.hdr_ready(hdr_ready)
	);

	cart_quirk_table u_quirks (
		.clk_sys(clk_sys), .RESET(RESET),
		.cart_download(cart_download), .cart_id(cart_id), .id_check(id_check),
		.sram_quirk(sram_quirk), .eeprom_quirk(eeprom_quirk),
		.fifo_quirk(fifo_quirk), .svp_quirk(svp_quirk),
		.gun_type(gun_type), .gun_delay(gun_delay)
	);

	region_select u_region (
		.clk_sys(clk_sys), .RESET(RESET),
		.hdr_ready(hdr_ready), .hdr_flags(hdr_flags_out),
		.auto_disable(auto_disable), .use_header(use_header),
		.region_priority(region_priority), .download_index(download_index),
		.region_req(region_req), .region_set(region_set)
	);

endmodule

`default_nettype wire

// ==== verilog/rom_write_bridge.sv ====
// ROM write bridge: one-deep buffer from the download stream to ROM memory with toggle handshake
`timescale 1ns/1ps
`default_nettype none

`include "cart_settings.svh"

module rom_write_bridge (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_download,
	input  logic                 ioctl_wr,
	input  cart_pkg::cart_addr_t ioctl_addr,
	input  cart_pkg::cart_word_t ioctl_data,
	output logic                 ioctl_wait,
	output cart_pkg::rom_addr_t  mem_addr,
	output cart_pkg::cart_word_t mem_data,
	output logic                 mem_req,
	input  logic                 mem_ack,
	output cart_pkg::cart_addr_t rom_size
);
	import cart_pkg::*;

	logic       old_download;
	logic       rom_wr;
	cart_word_t swap_data;

	assign rom_wr    = cart_download & ioctl_wr;
	assign swap_data = {ioctl_data[7:0], ioctl_data[15:8]};  // ROM is big-endian

	//////////////////////////////////////////////////////////////////////
	// Write buffer, held while the request is pending

	always_ff @(posedge clk_sys) begin
		if (rom_wr) begin
			mem_addr <= ioctl_addr[`CART_ADDR_W-1:1];
			mem_data <= swap_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Handshake and size capture

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			mem_req      <= 1'b0;
			ioctl_wait   <= 1'b0;
			rom_size     <= '0;
		end else begin
			old_download <= cart_download;

			// Last address of the image
			if (old_download & ~cart_download)
				rom_size <= ioctl_addr;

			if (rom_wr) begin
				mem_req    <= ~mem_req;          // Pending until ack matches
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && (mem_req == mem_ack)) begin
				ioctl_wait <= 1'b0;
			end
		end
	end

	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (RESET)
		ioctl_wait |-> !ioctl_wr);

endmodule

`default_nettype wire

// ==== verilog/region_select.sv ====
// Region selector: picks the console region once the cartridge header is complete
`timescale 1ns/1ps
`default_nettype none

module region_select (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    hdr_ready,
	input  cart_pkg::region_flags_t hdr_flags,
	input  logic                    auto_disable,
	input  logic                    use_header,
	input  cart_pkg::region_order_t region_priority,
	input  logic [7:0]              download_index,
	output cart_pkg::region_t       region_req,
	output logic                    region_set
);
	import cart_pkg::*;

	logic old_ready;

	// First flagged region of the order, else the order's own fallback
	function automatic region_t pick_region(input region_order_t order,
		input region_flags_t flags);
		logic    j;
		logic    u;
		logic    e;
		region_t r;
		j = flags[FLAG_J];
		u = flags[FLAG_U];
		e = flags[FLAG_E];
		case (order)
			ORDER_US_EU_JP: r = u ? REGION_US : e ? REGION_EU : j ? REGION_JP : REGION_US;
			ORDER_EU_US_JP: r = e ? REGION_EU : u ? REGION_US : j ? REGION_JP : REGION_EU;
			ORDER_US_JP_EU: r = u ? REGION_US : j ? REGION_JP : e ? REGION_EU : REGION_US;
			default:        r = j ? REGION_JP : u ? REGION_US : e ? REGION_EU : REGION_JP;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ready  <= 1'b0;
			region_req <= REGION_JP;
			region_set <= 1'b0;
		end else begin
			old_ready <= hdr_ready;

			if (hdr_ready & ~old_ready & ~auto_disable) begin
				if (use_header) begin
					region_req <= pick_region(region_priority, hdr_flags);
					region_set <= 1'b1;
				end else begin
					// Region comes from the file extension slot
					region_req <= region_t'(download_index[7:6]);
					region_set <= |download_index;
				end
			end

			if (~hdr_ready & old_ready)
				region_set <= 1'b0;           // Download over
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cart_quirk_table.sv ====
// Title table: matches the product code to compatibility quirks and light gun settings
`timescale 1ns/1ps
`default_nettype none

`include "cart_settings.svh"

module cart_quirk_table (
	input  logic                 clk_sys,
	input  logic                 RESET,
	input  logic                 cart_download,
	input  cart_pkg::cart_id_t   cart_id,
	input  logic                 id_check,
	output logic                 sram_quirk,
	output logic                 eeprom_quirk,
	output logic                 fifo_quirk,
	output logic                 svp_quirk,
	output logic                 gun_type,
	output cart_pkg::gun_delay_t gun_delay
);
	import cart_pkg::*;

	localparam gun_delay_t GUN_DELAY_DEFAULT = gun_delay_t'(`CART_GUN_DELAY_DEFAULT);

	logic old_download;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			sram_quirk   <= 1'b0;
			eeprom_quirk <= 1'b0;
			fifo_quirk   <= 1'b0;
			svp_quirk    <= 1'b0;
			gun_type     <= 1'b0;
			gun_delay    <= GUN_DELAY_DEFAULT;
		end else begin
			old_download <= cart_download;

			// Quirks belong to one image, gun settings stay until the next check
			if (cart_download & ~old_download) begin
				sram_quirk   <= 1'b0;
				eeprom_quirk <= 1'b0;
				fifo_quirk   <= 1'b0;
				svp_quirk    <= 1'b0;
			end

			if (id_check) begin
				case (cart_id)
					"T-081276", "T-81406 ", "T-081586": sram_quirk <= 1'b1;
					"MK-1215 ", "G-4060  ", "T-12046 ": eeprom_quirk <= 1'b1;
					"T-89016 ": fifo_quirk <= 1'b1;        // Clue
					"MK-1229 ", "G-7001  ": svp_quirk <= 1'b1;   // Virtua Racing
					default: ;
				endcase

				//////////////////////////////////////////////////////////////////////
				// Light gun titles, type 1 is the Justifier
				case (cart_id)
					"MK-1533 ": begin                  // Body Count
						gun_type  <= 1'b0;
						gun_delay <= 8'd100;
					end
					"T-95096-": begin                  // Lethal Enforcers
						gun_type  <= 1'b1;
						gun_delay <= 8'd52;
					end
					"T-95136-": begin
						gun_type  <= 1'b1;
						gun_delay <= 8'd30;
					end
					"MK-1658 ": begin                  // Menacer 6-in-1
						gun_type  <= 1'b0;
						gun_delay <= 8'd120;
					end
					"T-081156": begin
						gun_type  <= 1'b0;
						gun_delay <= 8'd126;
					end
					default: begin
						gun_type  <= 1'b0;
						gun_delay <= GUN_DELAY_DEFAULT;
					end
				endcase
			end
		end
	end

	a_one_quirk: assert property (@(posedge clk_sys) disable iff (RESET)
		$onehot0({sram_quirk, eeprom_quirk, fifo_quirk, svp_quirk}));

endmodule

`default_nettype wire

// ==== verilog/cart_header_scan.sv ====
// Header scanner: watches download writes for the region string and the product code
`timescale 1ns/1ps
`default_nettype none

`include "cart_settings.svh"

module cart_header_scan (
	input  logic                    clk_sys,
	input  logic                    RESET,
	input  logic                    cart_download,
	input  logic                    ioctl_wr,
	input  cart_pkg::cart_addr_t    ioctl_addr,
	input  cart_pkg::cart_word_t    ioctl_data,
	output cart_pkg::region_flags_t hdr_flags,
	output cart_pkg::cart_id_t      cart_id,
	output logic                    id_check,
	output logic                    hdr_ready
);
	import cart_pkg::*;

	logic          old_download;
	logic          hdr_wr;
	logic [7:0]    lo_byte;
	logic [7:0]    hi_byte;
	logic [3:0]    hex_nib;
	region_flags_t lo_letter;
	region_flags_t hi_letter;
	region_flags_t code_flags;
	region_flags_t region0_flags;

	// One flag per region letter, nothing for other characters
	function automatic region_flags_t letter_flags(input logic [7:0] ch);
		region_flags_t f;
		f = '0;
		case (ch)
			"J": f[FLAG_J] = 1'b1;
			"U": f[FLAG_U] = 1'b1;
			"E": f[FLAG_E] = 1'b1;
			default: f = '0;
		endcase
		return f;
	endfunction

	assign hdr_wr  = ioctl_wr & cart_download;
	assign lo_byte = ioctl_data[7:0];     // Even byte of the word
	assign hi_byte = ioctl_data[15:8];
	assign hex_nib = lo_byte[3:0] - 4'd7; // 'A'..'F' maps to 10..15

	assign lo_letter = letter_flags(lo_byte);
	assign hi_letter = letter_flags(hi_byte);

	//////////////////////////////////////////////////////////////////////
	// Region flags

	// Numeric region code replaces all three flags
	always_comb begin
		code_flags = hdr_flags;
		if (lo_byte >= "0" && lo_byte <= "9")
			code_flags = {lo_byte[3], lo_byte[2], lo_byte[0]};
		else if (lo_byte >= "A" && lo_byte <= "F")
			code_flags = {hex_nib[3], hex_nib[2], hex_nib[0]};
	end

	// Letter in the low byte wins over a code, high byte letter adds on top
	assign region0_flags = ((|lo_letter) ? (hdr_flags | lo_letter) : code_flags) | hi_letter;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			hdr_flags    <= '0;
			hdr_ready    <= 1'b0;
		end else begin
			old_download <= cart_download;

			if (cart_download & ~old_download)
				hdr_flags <= '0;               // New image
			if (~cart_download & old_download)
				hdr_ready <= 1'b0;

			if (hdr_wr) begin
				if (ioctl_addr == `CART_HDR_REGION0)
					hdr_flags <= region0_flags;
				if (ioctl_addr == `CART_HDR_REGION1)
					hdr_flags <= hdr_flags | lo_letter;
				if (ioctl_addr == `CART_HDR_END)
					hdr_ready <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Product code, big-endian across the byte-pair words

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (ioctl_addr)
				`CART_HDR_ID_FIRST:     cart_id[63:56] <= hi_byte;
				`CART_HDR_ID_FIRST + 2: cart_id[55:40] <= {lo_byte, hi_byte};
				`CART_HDR_ID_FIRST + 4: cart_id[39:24] <= {lo_byte, hi_byte};
				`CART_HDR_ID_FIRST + 6: cart_id[23:8]  <= {lo_byte, hi_byte};
				`CART_HDR_ID_LAST:      cart_id[7:0]   <= lo_byte;
				default: ;
			endcase
		end
	end

	// Code is already complete on this write
	assign id_check = hdr_wr & (ioctl_addr == `CART_HDR_ID_CHECK);

	a_ready_in_download: assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(hdr_ready) |-> $past(cart_download));

endmodule

`default_nettype wire

// ==== verilog/cart_pkg.sv ====
// Shared vector types and region enums, imported by the cartridge loader modules
`default_nettype none

`include "cart_settings.svh"

package cart_pkg;

	// Download stream
	typedef logic [`CART_ADDR_W-1:0] cart_addr_t;   // Byte address
	typedef logic [`CART_DATA_W-1:0] cart_word_t;

	// ROM side works in words, so one address bit less
	typedef logic [`CART_ADDR_W-2:0] rom_addr_t;

	// Product code, first character in the top byte
	typedef logic [`CART_ID_W-1:0] cart_id_t;

	typedef logic [7:0] gun_delay_t;                 // Light gun sensor delay

	// Region letters seen in the header, {E, U, J}
	typedef logic [2:0] region_flags_t;

	localparam int unsigned FLAG_J = 0;
	localparam int unsigned FLAG_U = 1;
	localparam int unsigned FLAG_E = 2;

	// Console region as requested from the core
	typedef enum logic [1:0] {
		REGION_JP = 2'd0,
		REGION_US = 2'd1,
		REGION_EU = 2'd2
	} region_t;

	// Header priority orders, first listed region is also the fallback
	typedef enum logic [1:0] {
		ORDER_US_EU_JP = 2'd0,
		ORDER_EU_US_JP = 2'd1,
		ORDER_US_JP_EU = 2'd2,
		ORDER_JP_US_EU = 2'd3
	} region_order_t;

endpackage

`default_nettype wire

// ==== verilog/cart_settings.svh ====
// Cartridge loader constants (widths, header offsets, gun default), included by loader sources
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths

// Byte address of the download stream
`define CART_ADDR_W 25

`define CART_DATA_W 16          // Download and ROM word

// Eight ASCII characters of the product code
`define CART_ID_W 64

//////////////////////////////////////////////////////////////////////
// Cartridge header layout, byte offsets of 16-bit words

// Product code words, first holds only its high byte
`define CART_HDR_ID_FIRST 'h182
`define CART_HDR_ID_LAST  'h18A

// Product code is complete and compared here
`define CART_HDR_ID_CHECK 'h18C

// Region string words
`define CART_HDR_REGION0 'h1F0
`define CART_HDR_REGION1 'h1F2

`define CART_HDR_END 'h200      // Whole header has been seen

//////////////////////////////////////////////////////////////////////
// Light gun

// Sensor delay used by titles without their own entry
`define CART_GUN_DELAY_DEFAULT 44

`endif
